// File: source/fifo_params.svh
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// write port width in bits
`define FIFO_W_DATA_W 8

// read port width in bits
`define FIFO_R_DATA_W 32

// byte address width, 64 bytes of storage
`define FIFO_ADDR_W 6

// level counter needs one extra bit to reach full
`define FIFO_LEVEL_W (`FIFO_ADDR_W + 1)

// depth in bytes
`define FIFO_DEPTH (1 << `FIFO_ADDR_W)

// width helpers for the asymmetric ports
`define FIFO_MAX(a, b) (((a) > (b)) ? (a) : (b))
`define FIFO_MIN(a, b) (((a) < (b)) ? (a) : (b))

`endif

// File: source/fifo_pkg.sv
`include "fifo_params.svh"

package fifo_pkg;

   // write strobe and its byte
   typedef struct packed {
      logic                      en;
      logic [`FIFO_W_DATA_W-1:0] data;
   } wr_req_t;

   // fill level classification, state of the level monitor
   typedef enum logic [1:0] {
      zone_low  = 2'd0,
      zone_mid  = 2'd1,
      zone_high = 2'd2
   } level_zone_t;

   // status word seen by the host
   typedef struct packed {
      logic                     empty;
      logic                     full;
      logic                     almost_empty;
      logic                     almost_full;
      level_zone_t              zone;
      logic [`FIFO_LEVEL_W-1:0] level;
   } fifo_status_t;

endpackage

// File: source/ram_2p_asym.sv
`timescale 1ns/10ps
`include "fifo_params.svh"

module ram_2p_asym #(
   parameter int W_DATA_W = `FIFO_W_DATA_W,
   parameter int R_DATA_W = `FIFO_R_DATA_W,
   // address width of the narrower port
   parameter int ADDR_W = `FIFO_ADDR_W,
   localparam int MAXDATA_W = `FIFO_MAX(W_DATA_W, R_DATA_W),
   localparam int MINDATA_W = `FIFO_MIN(W_DATA_W, R_DATA_W),
   localparam int RATIO = MAXDATA_W / MINDATA_W,
   localparam int RATIO_W = $clog2(RATIO),
   localparam int MINADDR_W = ADDR_W - RATIO_W,
   localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                clk,
   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   // storage in units of the narrower port
   logic [MINDATA_W-1:0] mem [2**ADDR_W];

   // output register starts at zero
   logic [R_DATA_W-1:0] r_data_q = '0;

   generate
      if (W_DATA_W > R_DATA_W) begin : g_wide_write
         // split the wide word, lowest slice to lowest address
         always_ff @(posedge clk) begin
            if (w_en) begin
               for (int i = 0; i < RATIO; i++) begin
                  mem[{w_addr, RATIO_W'(i)}] <= w_data[i*MINDATA_W +: MINDATA_W];
               end
            end
            if (r_en) begin
               r_data_q <= mem[r_addr];
            end
         end
      end else if (R_DATA_W > W_DATA_W) begin : g_wide_read
         // gather consecutive entries, first written ends up in the low bits
         always_ff @(posedge clk) begin
            if (w_en) begin
               mem[w_addr] <= w_data;
            end
            if (r_en) begin
               for (int i = 0; i < RATIO; i++) begin
                  r_data_q[i*MINDATA_W +: MINDATA_W] <= mem[{r_addr, RATIO_W'(i)}];
               end
            end
         end
      end else begin : g_symmetric
         always_ff @(posedge clk) begin
            if (w_en) begin
               mem[w_addr] <= w_data;
            end
            if (r_en) begin
               r_data_q <= mem[r_addr];
            end
         end
      end
   endgenerate

   assign r_data = r_data_q;

endmodule

// File: source/fifo_sync_asym.sv
`timescale 1ns/10ps
`include "fifo_params.svh"

module fifo_sync_asym (
   input  logic                      clk,
   input  logic                      reset,
   input  fifo_pkg::wr_req_t         wr,
   input  logic                      r_en,
   output logic [`FIFO_R_DATA_W-1:0] r_data,
   output logic                      empty,
   output logic                      full,
   output logic [`FIFO_LEVEL_W-1:0]  level
);

   localparam int W_DATA_W = `FIFO_W_DATA_W;
   localparam int R_DATA_W = `FIFO_R_DATA_W;
   localparam int ADDR_W = `FIFO_ADDR_W;
   localparam int LEVEL_W = `FIFO_LEVEL_W;

   // address widths per port, the wider port needs fewer bits
   localparam int MAXDATA_W = `FIFO_MAX(W_DATA_W, R_DATA_W);
   localparam int MINDATA_W = `FIFO_MIN(W_DATA_W, R_DATA_W);
   localparam int RATIO = MAXDATA_W / MINDATA_W;
   localparam int RATIO_W = $clog2(RATIO);
   localparam int MINADDR_W = ADDR_W - RATIO_W;
   localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

   // capacity in narrow units
   localparam logic [LEVEL_W-1:0] FIFO_SIZE = LEVEL_W'(`FIFO_DEPTH);

   // level step per access, in narrow units
   localparam logic [LEVEL_W-1:0] W_INCR =
      (W_DATA_W > R_DATA_W) ? LEVEL_W'(RATIO) : LEVEL_W'(1);
   localparam logic [LEVEL_W-1:0] R_INCR =
      (R_DATA_W > W_DATA_W) ? LEVEL_W'(RATIO) : LEVEL_W'(1);

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [LEVEL_W-1:0]  level_nxt;

   // refused strobes are simply dropped
   assign w_en_int = wr.en & ~full;
   assign r_en_int = r_en & ~empty;

   // write pointer, wraps at end of memory
   always_ff @(posedge clk) begin
      if (reset) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   // read pointer in word units
   always_ff @(posedge clk) begin
      if (reset) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   // next fill level
   always_comb begin
      level_nxt = level;
      if (w_en_int && !r_en_int) begin
         level_nxt = level + W_INCR;
      end else if (w_en_int && r_en_int) begin
         level_nxt = level + W_INCR - R_INCR;
      end else if (!w_en_int && r_en_int) begin
         level_nxt = level - R_INCR;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         level <= '0;
      end else begin
         level <= level_nxt;
      end
   end

   // not enough stored for one read word
   assign empty = level < R_INCR;

   // no room for another write
   assign full = level > (FIFO_SIZE - W_INCR);

   ram_2p_asym #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) ram0 (
      .clk   (clk),
      .w_en  (w_en_int),
      .w_addr(w_addr),
      .w_data(wr.data),
      .r_en  (r_en_int),
      .r_addr(r_addr),
      .r_data(r_data)
   );

endmodule

// File: source/fifo_level_monitor.sv
`timescale 1ns/10ps
`include "fifo_params.svh"

module fifo_level_monitor (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`FIFO_LEVEL_W-1:0] level,
   input  logic [`FIFO_LEVEL_W-1:0] ae_thresh,
   input  logic [`FIFO_LEVEL_W-1:0] af_thresh,
   output logic                     almost_empty,
   output logic                     almost_full,
   output fifo_pkg::level_zone_t    zone
);

   fifo_pkg::level_zone_t zone_nxt;
   logic                  ae_nxt;
   logic                  af_nxt;

   // classify the current level
   // low is checked first so it wins when thresholds overlap
   always_comb begin
      if (level <= ae_thresh) begin
         zone_nxt = fifo_pkg::zone_low;
      end else if (level >= af_thresh) begin
         zone_nxt = fifo_pkg::zone_high;
      end else begin
         zone_nxt = fifo_pkg::zone_mid;
      end
   end

   // flags follow the zone decision
   assign ae_nxt = (zone_nxt == fifo_pkg::zone_low);
   assign af_nxt = (zone_nxt == fifo_pkg::zone_high);

   // zone state register
   always_ff @(posedge clk) begin
      if (reset) begin
         zone <= fifo_pkg::zone_low;
      end else begin
         zone <= zone_nxt;
      end
   end

   // flag registers, one cycle behind level like the zone
   always_ff @(posedge clk) begin
      if (reset) begin
         almost_empty <= 1'b1;
         almost_full  <= 1'b0;
      end else begin
         almost_empty <= ae_nxt;
         almost_full  <= af_nxt;
      end
   end

endmodule

// File: source/fifo_buffer_top.sv
`timescale 1ns/10ps
`include "fifo_params.svh"

module fifo_buffer_top (
   input  logic                      clk,
   input  logic                      reset,
   input  fifo_pkg::wr_req_t         wr,
   input  logic                      r_en,
   input  logic [`FIFO_LEVEL_W-1:0]  ae_thresh,
   input  logic [`FIFO_LEVEL_W-1:0]  af_thresh,
   output logic [`FIFO_R_DATA_W-1:0] r_data,
   output fifo_pkg::fifo_status_t    status
);

   logic                     fifo_empty;
   logic                     fifo_full;
   logic [`FIFO_LEVEL_W-1:0] fifo_level;
   logic                     mon_almost_empty;
   logic                     mon_almost_full;
   fifo_pkg::level_zone_t    mon_zone;

   // byte in, word out
   fifo_sync_asym fifo0 (
      .clk   (clk),
      .reset (reset),
      .wr    (wr),
      .r_en  (r_en),
      .r_data(r_data),
      .empty (fifo_empty),
      .full  (fifo_full),
      .level (fifo_level)
   );

   // watermark flags against host thresholds
   fifo_level_monitor mon0 (
      .clk         (clk),
      .reset       (reset),
      .level       (fifo_level),
      .ae_thresh   (ae_thresh),
      .af_thresh   (af_thresh),
      .almost_empty(mon_almost_empty),
      .almost_full (mon_almost_full),
      .zone        (mon_zone)
   );

   // empty, full and level are live, the rest lag by a cycle
   assign status = '{
      empty:        fifo_empty,
      full:         fifo_full,
      almost_empty: mon_almost_empty,
      almost_full:  mon_almost_full,
      zone:         mon_zone,
      level:        fifo_level
   };

endmodule

// File: tb/fifo_buffer_tb.sv
`timescale 1ns/10ps
`include "fifo_params.svh"

module fifo_buffer_tb;

   localparam int CLK_PERIOD = 10;
   localparam int RESET_CYCLES = 4;
   localparam int CYCLES_PER_LINE = 20;
   localparam int RAND_SEED = 86;
   localparam string GOLDEN_FILE = "tb/fifo_buffer_golden.txt";

   logic                      clk;
   logic                      reset;
   fifo_pkg::wr_req_t         wr;
   logic                      r_en;
   logic [`FIFO_LEVEL_W-1:0]  ae_thresh;
   logic [`FIFO_LEVEL_W-1:0]  af_thresh;
   logic [`FIFO_R_DATA_W-1:0] r_data;
   fifo_pkg::fifo_status_t    status;

   int timeout_cycles = 0;
   int ops_done = 0;

   fifo_buffer_top dut0 (
      .clk      (clk),
      .reset    (reset),
      .wr       (wr),
      .r_en     (r_en),
      .ae_thresh(ae_thresh),
      .af_thresh(af_thresh),
      .r_data   (r_data),
      .status   (status)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1);
   endtask

   function automatic string describe_status(input fifo_pkg::fifo_status_t s);
      return $sformatf("level=%0d empty=%b full=%b almost_empty=%b almost_full=%b zone=%0d",
                       s.level, s.empty, s.full, s.almost_empty, s.almost_full, s.zone);
   endfunction

   task automatic compare_word(input string name,
                               input logic [`FIFO_R_DATA_W-1:0] expected,
                               input logic [`FIFO_R_DATA_W-1:0] actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("ERR t=%0t %s expected=%h actual=%h",
                                     $time, name, expected, actual));
      end
   endtask

   task automatic compare_status(input string name,
                                 input fifo_pkg::fifo_status_t expected,
                                 input fifo_pkg::fifo_status_t actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("ERR t=%0t %s expected=(%s) actual=(%s)",
                                     $time, name, describe_status(expected),
                                     describe_status(actual)));
      end
   endtask

   // status and read word as left by the last reset edge
   task automatic confirm_reset_state();
      fifo_pkg::fifo_status_t expected;
      expected.empty = 1'b1;
      expected.full = 1'b0;
      expected.almost_empty = 1'b1;
      expected.almost_full = 1'b0;
      expected.zone = fifo_pkg::zone_low;
      expected.level = '0;
      compare_status("status", expected, status);
      compare_word("r_data", '0, r_data);
   endtask

   // one burst of back to back byte writes
   task automatic write_run(input int count, input logic [`FIFO_W_DATA_W-1:0] first);
      @(posedge clk);
      for (int i = 0; i < count; i++) begin
         wr <= '{en: 1'b1, data: `FIFO_W_DATA_W'(first + i)};
         @(posedge clk);
      end
      wr <= '0;
   endtask

   task automatic read_word(input logic [`FIFO_R_DATA_W-1:0] expected);
      @(posedge clk);
      r_en <= 1'b1;
      @(posedge clk);
      r_en <= 1'b0;
      // word registered at the edge that took the strobe
      @(negedge clk);
      compare_word("r_data", expected, r_data);
   endtask

   // write and read on the same edge
   task automatic write_read(input logic [`FIFO_W_DATA_W-1:0] data,
                             input logic [`FIFO_R_DATA_W-1:0] expected);
      @(posedge clk);
      wr <= '{en: 1'b1, data: data};
      r_en <= 1'b1;
      @(posedge clk);
      wr <= '0;
      r_en <= 1'b0;
      @(negedge clk);
      compare_word("r_data", expected, r_data);
   endtask

   task automatic set_thresholds(input int ae, input int af);
      @(posedge clk);
      ae_thresh <= `FIFO_LEVEL_W'(ae);
      af_thresh <= `FIFO_LEVEL_W'(af);
   endtask

   // one extra edge so the monitor registers catch up
   task automatic check_status(input int lvl, input int e, input int f,
                               input int ae, input int af, input int z);
      fifo_pkg::fifo_status_t expected;
      expected.empty = e[0];
      expected.full = f[0];
      expected.almost_empty = ae[0];
      expected.almost_full = af[0];
      expected.zone = fifo_pkg::level_zone_t'(z);
      expected.level = `FIFO_LEVEL_W'(lvl);
      @(posedge clk);
      @(negedge clk);
      compare_status("status", expected, status);
   endtask

   task automatic idle_gap();
      int cycles;
      cycles = $urandom % 4;
      repeat (cycles) @(posedge clk);
   endtask

   task automatic expect_fields(input int got, input int want, input logic [7:0] op);
      if (got != want) begin
         stop_with_failure($sformatf("malformed golden line for opcode %c", op));
      end
   endtask

   task automatic count_lines(output int lines);
      int fd;
      logic [8*256-1:0] text;
      lines = 0;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         stop_with_failure("could not open the golden file");
      end
      while ($fgets(text, fd) != 0) begin
         lines++;
      end
      $fclose(fd);
   endtask

   task automatic run_golden_file();
      int fd;
      int n;
      int count;
      int lvl;
      int e;
      int f;
      int ae;
      int af;
      int z;
      logic [7:0] op;
      logic [8*256-1:0] rest;
      logic [`FIFO_W_DATA_W-1:0] data;
      logic [`FIFO_R_DATA_W-1:0] word;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         stop_with_failure("could not open the golden file");
      end
      while (!$feof(fd)) begin
         n = $fscanf(fd, " %c", op);
         if (n == 1) begin
            case (op)
               "#": n = $fgets(rest, fd);
               "W": begin
                  n = $fscanf(fd, " %h", data);
                  expect_fields(n, 1, op);
                  write_run(1, data);
               end
               "F": begin
                  n = $fscanf(fd, " %d %h", count, data);
                  expect_fields(n, 2, op);
                  write_run(count, data);
               end
               "R": begin
                  n = $fscanf(fd, " %h", word);
                  expect_fields(n, 1, op);
                  read_word(word);
               end
               "B": begin
                  n = $fscanf(fd, " %h %h", data, word);
                  expect_fields(n, 2, op);
                  write_read(data, word);
               end
               "S": begin
                  n = $fscanf(fd, " %d %d %d %d %d %d", lvl, e, f, ae, af, z);
                  expect_fields(n, 6, op);
                  check_status(lvl, e, f, ae, af, z);
               end
               "T": begin
                  n = $fscanf(fd, " %d %d", ae, af);
                  expect_fields(n, 2, op);
                  set_thresholds(ae, af);
               end
               default: stop_with_failure($sformatf("unknown opcode %c in golden file", op));
            endcase
            if (op != "#") begin
               ops_done++;
               idle_gap();
            end
         end
      end
      $fclose(fd);
   endtask

   initial begin : watchdog
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge clk);
      stop_with_failure($sformatf("the run timed out after %0d clock cycles", timeout_cycles));
   end

   initial begin : main
      int lines;
      void'($urandom(RAND_SEED));
      reset = 1'b1;
      wr = '0;
      r_en = 1'b0;
      ae_thresh = `FIFO_LEVEL_W'(4);
      af_thresh = `FIFO_LEVEL_W'(60);
      count_lines(lines);
      timeout_cycles = RESET_CYCLES + CYCLES_PER_LINE * lines;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      // no active edge yet since the last reset edge
      @(negedge clk);
      confirm_reset_state();
      run_golden_file();
      if (ops_done > 0) begin
         $display("sim passed");
         $finish;
      end else begin
         stop_with_failure("the golden file held no operations");
      end
   end

endmodule

// File: tb/fifo_buffer_golden.txt
# op: W byte | F count first_byte | R word | B byte word   (bytes and words in hex)
# op: S level empty full almost_empty almost_full zone | T ae_thresh af_thresh (decimal)
# reset state, thresholds start at 4 and 60
S 0 1 0 1 0 0
R 00000000
S 0 1 0 1 0 0
# packing order, underflow read with three bytes stored
W 11
W 22
W 33
S 3 1 0 1 0 0
R 00000000
S 3 1 0 1 0 0
W 44
S 4 0 0 1 0 0
R 44332211
S 0 1 0 1 0 0
# fill to full, extra byte dropped
F 64 00
S 64 0 1 0 1 2
W FF
S 64 0 1 0 1 2
R 03020100
S 60 0 0 0 1 2
# write and read together, read pointer wraps
B C0 07060504
S 57 0 0 0 0 1
B C1 0B0A0908
B C2 0F0E0D0C
B C3 13121110
B C4 17161514
B C5 1B1A1918
B C6 1F1E1D1C
B C7 23222120
B C8 27262524
B C9 2B2A2928
B CA 2F2E2D2C
B CB 33323130
B CC 37363534
B CD 3B3A3938
B CE 3F3E3D3C
S 15 0 0 0 0 1
R C3C2C1C0
R C7C6C5C4
R CBCAC9C8
S 3 1 0 1 0 0
R CBCAC9C8
S 3 1 0 1 0 0
# threshold zones
T 8 12
S 3 1 0 1 0 0
F 6 D0
S 9 0 0 0 0 1
F 3 D6
S 12 0 0 0 1 2
# overlapping thresholds, low wins
T 20 10
S 12 0 0 1 0 0
T 11 12
S 12 0 0 0 1 2
R D0CECDCC
S 8 0 0 1 0 0
R D4D3D2D1
R D8D7D6D5
S 0 1 0 1 0 0

// File: src.f
+incdir+source
source/fifo_pkg.sv
source/ram_2p_asym.sv
source/fifo_sync_asym.sv
source/fifo_level_monitor.sv
source/fifo_buffer_top.sv
tb/fifo_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fifo buffer testbench with verilator
set -e

cd "$(dirname "$0")"

TOP=fifo_buffer_tb
BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"
rm -f "$LOG"

verilator --binary --timing -Wno-fatal \
   --top-module "$TOP" \
   --Mdir "$BUILD_DIR" \
   -f src.f

# a fatal stop exits nonzero, keep going so the log is shown
"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "sim passed" "$LOG"; then
   echo "result: PASS"
else
   echo "result: FAIL"
   exit 1
fi
